/* rtl/cdb_pkg.sv */
`default_nettype none

package cdb_pkg;

    // Width of a result word
    localparam int XLEN = 32;

    // Result value carried on the bus
    typedef logic [XLEN-1:0] word_t;

    // Reorder buffer entry index
    typedef logic [4:0] rob_tag_t;

    // Architectural register index
    typedef logic [4:0] reg_addr_t;

    // Functional unit index, room for up to 8 units
    typedef logic [2:0] fu_sel_t;

    // Default number of functional units feeding the bus
    localparam int NUM_FU_DEFAULT = 5;

    // Default number of entries per result queue
    localparam int QUEUE_DEPTH_DEFAULT = 2;

endpackage

`default_nettype wire

/* rtl/fu_result_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fu_result_queue #(
    parameter int QUEUE_DEPTH = cdb_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  cdb_pkg::rob_tag_t  in_tag,
    input  cdb_pkg::reg_addr_t in_addr,
    input  cdb_pkg::word_t     in_value,
    output logic               out_valid,
    input  logic               pop,
    output cdb_pkg::rob_tag_t  out_tag,
    output cdb_pkg::reg_addr_t out_addr,
    output cdb_pkg::word_t     out_value
);
    import cdb_pkg::*;

    // Pointer needs at least one bit even for a single entry
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Entry storage
    rob_tag_t  tag_mem   [QUEUE_DEPTH];
    reg_addr_t addr_mem  [QUEUE_DEPTH];
    word_t     value_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             do_pop;

    assign full      = (count == CNT_W'(QUEUE_DEPTH));
    assign out_valid = (count != '0);
    // A full queue still takes a result when the head leaves this cycle
    assign in_ready  = !full || pop;
    assign push      = in_valid && in_ready;
    // Pop only counts when there is a head to consume
    assign do_pop    = pop && out_valid;

    // Oldest entry is always at the head
    assign out_tag   = tag_mem[rd_ptr];
    assign out_addr  = addr_mem[rd_ptr];
    assign out_value = value_mem[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Write the accepted result at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            tag_mem[wr_ptr]   <= in_tag;
            addr_mem[wr_ptr]  <= in_addr;
            value_mem[wr_ptr] <= in_value;
        end
    end

endmodule

`default_nettype wire

/* rtl/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter #(
    parameter int NUM_FU = cdb_pkg::NUM_FU_DEFAULT
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [NUM_FU-1:0] req,
    output logic              grant_valid,
    output cdb_pkg::fu_sel_t  grant
);
    import cdb_pkg::*;

    // Unit with highest priority this cycle
    fu_sel_t ptr;

    // Search from the pointer upward with wrap
    // First requester found wins
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant       = '0;
        idx         = 0;
        for (int k = 0; k < NUM_FU; k++) begin
            idx = (int'(ptr) + k) % NUM_FU;
            if (!grant_valid && req[idx]) begin
                grant_valid = 1'b1;
                grant       = fu_sel_t'(idx);
            end
        end
    end

    // Priority moves past the winner
    // A unit that keeps requesting waits at most NUM_FU-1 grants
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (grant_valid) begin
            if (grant == fu_sel_t'(NUM_FU - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/cdb.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb #(
    parameter int NUM_FU = cdb_pkg::NUM_FU_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            select_flag,
    input  cdb_pkg::fu_sel_t                select,
    input  cdb_pkg::rob_tag_t  [NUM_FU-1:0] in_tag,
    input  cdb_pkg::reg_addr_t [NUM_FU-1:0] in_addr,
    input  cdb_pkg::word_t     [NUM_FU-1:0] in_value,
    output logic                            bcast_valid,
    output cdb_pkg::rob_tag_t               bcast_tag,
    output cdb_pkg::reg_addr_t              bcast_addr,
    output cdb_pkg::word_t                  bcast_value
);
    import cdb_pkg::*;

    // Chosen result before the output flops
    rob_tag_t  sel_tag;
    reg_addr_t sel_addr;
    word_t     sel_value;

    // Result mux driven by the arbiter grant
    always_comb begin
        if (select_flag && (int'(select) < NUM_FU)) begin
            sel_tag   = in_tag[select];
            sel_addr  = in_addr[select];
            sel_value = in_value[select];
        end else begin
            // Idle bus carries zeros
            sel_tag   = '0;
            sel_addr  = '0;
            sel_value = '0;
        end
    end

    // Bus driven from flops
    // Each grant gives exactly one broadcast cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bcast_valid <= 1'b0;
            bcast_tag   <= '0;
            bcast_addr  <= '0;
            bcast_value <= '0;
        end else begin
            bcast_valid <= select_flag;
            bcast_tag   <= sel_tag;
            bcast_addr  <= sel_addr;
            bcast_value <= sel_value;
        end
    end

endmodule

`default_nettype wire

/* rtl/arch_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  cdb_pkg::reg_addr_t wr_addr,
    input  cdb_pkg::word_t     wr_data,
    input  cdb_pkg::reg_addr_t rd_addr,
    output cdb_pkg::word_t     rd_data
);
    import cdb_pkg::*;

    // One register per address value
    localparam int NUM_REGS = 1 << $bits(reg_addr_t);

    word_t regs [NUM_REGS];

    // Broadcast writes the destination register
    // Register zero never takes a write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational read
    // Register zero is hardwired to zero
    always_comb begin
        if (rd_addr == '0) begin
            rd_data = '0;
        end else begin
            rd_data = regs[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/cdb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_top #(
    parameter int NUM_FU      = cdb_pkg::NUM_FU_DEFAULT,
    parameter int QUEUE_DEPTH = cdb_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic               [NUM_FU-1:0] fu_valid,
    output logic               [NUM_FU-1:0] fu_ready,
    input  cdb_pkg::rob_tag_t  [NUM_FU-1:0] fu_tag,
    input  cdb_pkg::reg_addr_t [NUM_FU-1:0] fu_addr,
    input  cdb_pkg::word_t     [NUM_FU-1:0] fu_value,
    output logic                            bcast_valid,
    output cdb_pkg::rob_tag_t               bcast_tag,
    output cdb_pkg::reg_addr_t              bcast_addr,
    output cdb_pkg::word_t                  bcast_value,
    input  cdb_pkg::reg_addr_t              rd_addr,
    output cdb_pkg::word_t                  rd_data
);
    import cdb_pkg::*;

    // Queue heads seen by the arbiter and the bus mux
    logic      [NUM_FU-1:0] head_valid;
    rob_tag_t  [NUM_FU-1:0] head_tag;
    reg_addr_t [NUM_FU-1:0] head_addr;
    word_t     [NUM_FU-1:0] head_value;
    logic      [NUM_FU-1:0] head_pop;

    logic    grant_valid;
    fu_sel_t grant;

    // One result queue per functional unit
    for (genvar i = 0; i < NUM_FU; i++) begin : g_queue
        // Granted queue hands its head to the bus
        assign head_pop[i] = grant_valid && (grant == fu_sel_t'(i));

        fu_result_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) i_queue (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (fu_valid[i]),
            .in_ready  (fu_ready[i]),
            .in_tag    (fu_tag[i]),
            .in_addr   (fu_addr[i]),
            .in_value  (fu_value[i]),
            .out_valid (head_valid[i]),
            .pop       (head_pop[i]),
            .out_tag   (head_tag[i]),
            .out_addr  (head_addr[i]),
            .out_value (head_value[i])
        );
    end

    // Round-robin choice among non-empty queues
    cdb_arbiter #(
        .NUM_FU (NUM_FU)
    ) i_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (head_valid),
        .grant_valid (grant_valid),
        .grant       (grant)
    );

    // Registered broadcast of the granted head
    cdb #(
        .NUM_FU (NUM_FU)
    ) i_cdb (
        .clk         (clk),
        .rst_n       (rst_n),
        .select_flag (grant_valid),
        .select      (grant),
        .in_tag      (head_tag),
        .in_addr     (head_addr),
        .in_value    (head_value),
        .bcast_valid (bcast_valid),
        .bcast_tag   (bcast_tag),
        .bcast_addr  (bcast_addr),
        .bcast_value (bcast_value)
    );

    // Register file snoops the bus
    arch_reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (bcast_valid),
        .wr_addr (bcast_addr),
        .wr_data (bcast_value),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* dv/tb_cdb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cdb_top;
    import cdb_pkg::*;

    localparam int NUM_FU       = 5;
    localparam int QUEUE_DEPTH  = 2;
    localparam int NUM_TAGS     = 32;
    localparam int NUM_REGS     = 32;
    localparam int HEAVY_CYCLES = 300;
    localparam int LIGHT_CYCLES = 300;

    logic                   clk;
    logic                   rst_n;
    logic      [NUM_FU-1:0] fu_valid;
    logic      [NUM_FU-1:0] fu_ready;
    rob_tag_t  [NUM_FU-1:0] fu_tag;
    reg_addr_t [NUM_FU-1:0] fu_addr;
    word_t     [NUM_FU-1:0] fu_value;
    logic                   bcast_valid;
    rob_tag_t               bcast_tag;
    reg_addr_t              bcast_addr;
    word_t                  bcast_value;
    reg_addr_t              rd_addr;
    word_t                  rd_data;

    // Model state: 0 free, 1 offered, 2 accepted into a queue
    int        tag_state [NUM_TAGS];
    int        tag_owner [NUM_TAGS];
    reg_addr_t tag_addr  [NUM_TAGS];
    word_t     tag_value [NUM_TAGS];
    int        free_tags [$];
    // Accepted tags in acceptance order, oldest first
    int        accepted_q [$];
    int        queued_cnt [NUM_FU];
    int        others_cnt [NUM_FU];
    logic      [NUM_FU-1:0] had_work;
    logic      [NUM_FU-1:0] accept;
    word_t     exp_regs [NUM_REGS];

    logic [15:0] lfsr_state;
    // 0 idle, 1 heavy traffic, 2 light traffic
    int          mode;
    int          issued_count = 0;
    int          cycle_count;
    int          bp_count;
    // No broadcast and no unit offering in the last observed cycle
    logic        bus_idle;
    int          idle_cycles;

    cdb_top #(
        .NUM_FU      (NUM_FU),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .fu_valid    (fu_valid),
        .fu_ready    (fu_ready),
        .fu_tag      (fu_tag),
        .fu_addr     (fu_addr),
        .fu_value    (fu_value),
        .bcast_valid (bcast_valid),
        .bcast_tag   (bcast_tag),
        .bcast_addr  (bcast_addr),
        .bcast_value (bcast_value),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %0h actual %0h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // Sampled mid-cycle where every DUT output is settled
    task automatic observe_bus();
        int t;
        int u;
        int found;
        if (bcast_valid) begin
            t = int'(bcast_tag);
            check_value("bcast tag in flight", 2, tag_state[t]);
            u = tag_owner[t];
            found = -1;
            for (int j = 0; j < accepted_q.size(); j++) begin
                if (found < 0 && tag_owner[accepted_q[j]] == u) begin
                    found = j;
                end
            end
            // Results of one unit leave in the order they came in
            check_value("bcast oldest of unit", accepted_q[found], t);
            check_value("bcast addr", 32'(tag_addr[t]), 32'(bcast_addr));
            check_value("bcast value", tag_value[t], bcast_value);
            accepted_q.delete(found);
            queued_cnt[u]--;
            tag_state[t] = 0;
            free_tags.push_back(t);
            if (tag_addr[t] != '0) begin
                exp_regs[tag_addr[t]] = tag_value[t];
            end
            // Count foreign broadcasts seen by units that were waiting at the grant
            for (int v = 0; v < NUM_FU; v++) begin
                if (v == u || !had_work[v]) begin
                    others_cnt[v] = 0;
                end else begin
                    others_cnt[v]++;
                    check_value("fairness wait below NUM_FU", 1, 32'(others_cnt[v] < NUM_FU));
                end
            end
        end else begin
            // Idle bus carries zeros
            check_value("idle bcast tag", 0, 32'(bcast_tag));
            check_value("idle bcast addr", 0, 32'(bcast_addr));
            check_value("idle bcast value", 0, bcast_value);
        end
        for (int i = 0; i < NUM_FU; i++) begin
            // Ready drops only on a full queue that is not popping
            if (!fu_ready[i]) begin
                bp_count++;
                check_value("ready low only when full", QUEUE_DEPTH, queued_cnt[i]);
            end
            if (queued_cnt[i] < QUEUE_DEPTH) begin
                check_value("ready high while not full", 1, 32'(fu_ready[i]));
            end
            accept[i]   = fu_valid[i] && fu_ready[i];
            had_work[i] = (queued_cnt[i] > 0);
        end
        bus_idle = !bcast_valid && (fu_valid == '0);
    endtask

    task automatic accept_results();
        for (int i = 0; i < NUM_FU; i++) begin
            if (accept[i]) begin
                accepted_q.push_back(int'(fu_tag[i]));
                tag_state[fu_tag[i]] = 2;
                queued_cnt[i]++;
                fu_valid[i] = 1'b0;
            end
        end
    endtask

    // Units without a pending result may start a new one
    task automatic offer_results();
        int  t;
        bit  go;
        for (int i = 0; i < NUM_FU; i++) begin
            if (!fu_valid[i] && mode != 0 && free_tags.size() > 0) begin
                go = (mode == 1) ? (rand_bits(4) != 0) : (rand_bits(2) == 0);
                if (go) begin
                    t = free_tags.pop_front();
                    tag_state[t] = 1;
                    tag_owner[t] = i;
                    tag_addr[t]  = reg_addr_t'(rand_bits(5));
                    tag_value[t] = rand_bits(32);
                    fu_tag[i]    = rob_tag_t'(t);
                    fu_addr[i]   = tag_addr[t];
                    fu_value[i]  = tag_value[t];
                    fu_valid[i]  = 1'b1;
                    issued_count++;
                end
            end
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        observe_bus();
        @(posedge clk);
        #1;
        accept_results();
        offer_results();
    endtask

    // Limit grows with the traffic issued so far
    initial begin
        cycle_count = 0;
        while (cycle_count <= 20 * issued_count + 200) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles, results never drained", cycle_count);
        $display("=== FAIL ===");
        $fatal(1, "Timeout");
    end

    initial begin
        lfsr_state = 16'd89;
        rst_n      = 1'b0;
        fu_valid   = '0;
        fu_tag     = '0;
        fu_addr    = '0;
        fu_value   = '0;
        rd_addr    = '0;
        mode       = 0;
        bp_count   = 0;
        had_work   = '0;
        accept     = '0;
        bus_idle   = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            tag_state[t] = 0;
            free_tags.push_back(t);
        end
        for (int i = 0; i < NUM_FU; i++) begin
            queued_cnt[i] = 0;
            others_cnt[i] = 0;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            exp_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle bus, empty queues and cleared registers
        for (int k = 0; k < 4; k++) begin
            rd_addr = reg_addr_t'(rand_bits(5));
            @(negedge clk);
            check_value("bcast_valid after reset", 0, 32'(bcast_valid));
            check_value("fu_ready after reset", (1 << NUM_FU) - 1, 32'(fu_ready));
            check_value("rd_data after reset", 0, rd_data);
            @(posedge clk);
            #1;
        end

        // Sustained contention fills queues, then sparse traffic
        mode = 1;
        repeat (HEAVY_CYCLES) run_cycle();
        mode = 2;
        repeat (LIGHT_CYCLES) run_cycle();
        mode = 0;
        // Two idle cycles in a row mean no grant and no transfer left
        idle_cycles = 0;
        while (idle_cycles < 2) begin
            run_cycle();
            if (bus_idle) begin
                idle_cycles++;
            end else begin
                idle_cycles = 0;
            end
        end
        check_value("outstanding after drain", 0, accepted_q.size());
        check_value("back-pressure observed", 1, 32'(bp_count > 0));

        // Last write landed on the edge just passed
        for (int a = 0; a < NUM_REGS; a++) begin
            rd_addr = reg_addr_t'(a);
            @(negedge clk);
            check_value("register file read", exp_regs[a], rd_data);
            @(posedge clk);
            #1;
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/cdb_pkg.sv
rtl/fu_result_queue.sv
rtl/cdb_arbiter.sv
rtl/cdb.sv
rtl/arch_reg_file.sv
rtl/cdb_top.sv
dv/tb_cdb_top.sv

/* Makefile */
# Verilator build for the result broadcast stage
VERILATOR ?= verilator
TOP       ?= tb_cdb_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SIM       := $(BUILD_DIR)/V$(TOP)

SOURCES := $(wildcard rtl/*.sv) $(wildcard dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

# A failing check ends in $fatal, so the exit status carries the result
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)
